/* logic/stream_buffer_pkg.sv */
package stream_buffer_pkg;

	// one feature word as held in either bank.
	typedef logic [15:0] feature_t;

	// default bank geometry.
	localparam int DEF_ADDR_W = 14;

	// scan order, lane innermost, then channel step, then window.
	localparam int DEF_LANES = 4;
	localparam int DEF_CHANNELS = 4;
	localparam int DEF_WINDOW_STRIDE = 4;
	localparam int DEF_NUM_WINDOWS = 1444;

	// words the consumer can hold before it must hand credits back.
	localparam int DEF_CREDITS = 8;

	// address latch, array register and output stage of a bank.
	localparam int READ_LATENCY = 3;

endpackage

/* logic/feature_ram.sv */
`timescale 1ns/1ps

module feature_ram #(
	parameter int ADDR_W = stream_buffer_pkg::DEF_ADDR_W
) (
	input  logic                        clk,
	input  logic                        i_wen,
	input  logic [ADDR_W-1:0]           i_waddr,
	input  stream_buffer_pkg::feature_t i_wdata,
	input  logic [ADDR_W-1:0]           i_raddr,
	output stream_buffer_pkg::feature_t o_rdata
);

	import stream_buffer_pkg::*;

	localparam int DEPTH = 2 ** ADDR_W;

	feature_t          mem [0:DEPTH-1];
	logic [ADDR_W-1:0] raddr_q;
	feature_t          array_q;
	feature_t          pipe_q;

	// write port.
	always_ff @(posedge clk) begin
		if (i_wen) begin
			mem[i_waddr] <= i_wdata;
		end
	end

	// read port, three register stages from address to data.
	always_ff @(posedge clk) begin
		raddr_q <= i_raddr; // stage one.
		array_q <= mem[raddr_q]; // stage two.
		pipe_q  <= array_q; // stage three.
	end

	assign o_rdata = pipe_q;

endmodule

/* logic/scan_addr_gen.sv */
`timescale 1ns/1ps

module scan_addr_gen #(
	parameter int ADDR_W        = stream_buffer_pkg::DEF_ADDR_W,
	parameter int LANES         = stream_buffer_pkg::DEF_LANES,
	parameter int CHANNELS      = stream_buffer_pkg::DEF_CHANNELS,
	parameter int WINDOW_STRIDE = stream_buffer_pkg::DEF_WINDOW_STRIDE,
	parameter int NUM_WINDOWS   = stream_buffer_pkg::DEF_NUM_WINDOWS
) (
	input  logic              clk,
	input  logic              i_reset,
	input  logic              i_start,
	input  logic              i_advance,
	output logic [ADDR_W-1:0] o_raddr,
	output logic              o_active,
	output logic              o_last
);

	localparam int LANE_W = (LANES > 1) ? $clog2(LANES) : 1;
	localparam int CHAN_W = (CHANNELS > 1) ? $clog2(CHANNELS) : 1;
	localparam int WIN_W  = (NUM_WINDOWS > 1) ? $clog2(NUM_WINDOWS) : 1;

	logic [LANE_W-1:0] lane;
	logic [CHAN_W-1:0] chan;
	logic [WIN_W-1:0]  win;
	logic [ADDR_W-1:0] base;
	logic              active;
	logic              lane_wrap;
	logic              chan_wrap;
	logic              win_wrap;

	assign lane_wrap = (lane == LANE_W'(LANES - 1));
	assign chan_wrap = (chan == CHAN_W'(CHANNELS - 1));
	assign win_wrap  = (win == WIN_W'(NUM_WINDOWS - 1));

	// window base plus channel step plus lane.
	assign o_raddr  = base + ADDR_W'(chan) + ADDR_W'(lane);
	assign o_active = active;
	assign o_last   = active & lane_wrap & chan_wrap & win_wrap;

	always_ff @(posedge clk) begin
		if (i_reset) begin
			lane   <= '0;
			chan   <= '0;
			win    <= '0;
			base   <= '0;
			active <= 1'b0;
		end else if (!active) begin
			if (i_start) begin
				active <= 1'b1; // a start during a pass never gets here.
			end
		end else if (i_advance) begin
			if (o_last) begin
				lane   <= '0;
				chan   <= '0;
				win    <= '0;
				base   <= '0;
				active <= 1'b0;
			end else if (lane_wrap) begin
				lane <= '0;
				if (chan_wrap) begin
					chan <= '0;
					win  <= win + 1'b1;
					base <= base + ADDR_W'(WINDOW_STRIDE); // next window.
				end else begin
					chan <= chan + 1'b1;
				end
			end else begin
				lane <= lane + 1'b1;
			end
		end
	end

endmodule

/* logic/credit_sender.sv */
`timescale 1ns/1ps

module credit_sender #(
	parameter int CREDITS = stream_buffer_pkg::DEF_CREDITS
) (
	input  logic clk,
	input  logic i_reset,
	input  logic i_active,
	input  logic i_last,
	input  logic i_credit,
	output logic o_issue,
	output logic o_valid,
	output logic o_finished
);

	import stream_buffer_pkg::*;

	localparam int CNT_W = $clog2(CREDITS + 1);

	logic [CNT_W-1:0]        credit_cnt;
	logic [READ_LATENCY-1:0] valid_pipe;
	logic [READ_LATENCY-1:0] last_pipe;

	assign o_issue = i_active & (credit_cnt != '0);

	// a credit back in the same cycle as an issue cancels out.
	always_ff @(posedge clk) begin
		if (i_reset) begin
			credit_cnt <= CNT_W'(CREDITS);
		end else begin
			case ({o_issue, i_credit})
				2'b10:   credit_cnt <= credit_cnt - 1'b1;
				2'b01:   credit_cnt <= credit_cnt + 1'b1;
				default: credit_cnt <= credit_cnt;
			endcase
		end
	end

	// follows the word through the bank pipeline.
	always_ff @(posedge clk) begin
		if (i_reset) begin
			valid_pipe <= '0;
			last_pipe  <= '0;
		end else begin
			valid_pipe <= {valid_pipe[READ_LATENCY-2:0], o_issue};
			last_pipe  <= {last_pipe[READ_LATENCY-2:0], o_issue & i_last};
		end
	end

	assign o_valid    = valid_pipe[READ_LATENCY-1];
	assign o_finished = last_pipe[READ_LATENCY-1];

endmodule

/* logic/stream_buffer.sv */
`timescale 1ns/1ps

module stream_buffer #(
	parameter int ADDR_W        = stream_buffer_pkg::DEF_ADDR_W,
	parameter int LANES         = stream_buffer_pkg::DEF_LANES,
	parameter int CHANNELS      = stream_buffer_pkg::DEF_CHANNELS,
	parameter int WINDOW_STRIDE = stream_buffer_pkg::DEF_WINDOW_STRIDE,
	parameter int NUM_WINDOWS   = stream_buffer_pkg::DEF_NUM_WINDOWS,
	parameter int CREDITS       = stream_buffer_pkg::DEF_CREDITS
) (
	input  logic                        clk,
	input  logic                        i_reset,
	input  logic                        i_start,
	input  logic                        i_wen0,
	input  logic [ADDR_W-1:0]           i_waddr0,
	input  stream_buffer_pkg::feature_t i_ddr,
	input  logic                        i_wen1,
	input  logic [ADDR_W-1:0]           i_waddr1,
	input  stream_buffer_pkg::feature_t i_pool,
	input  stream_buffer_pkg::feature_t i_eltwise,
	input  logic                        i_eltwise_sel,
	input  logic                        i_credit_0,
	input  logic                        i_credit_1,
	output stream_buffer_pkg::feature_t o_feature_0,
	output logic                        o_valid_0,
	output stream_buffer_pkg::feature_t o_feature_1,
	output logic                        o_valid_1,
	output logic                        o_done
);

	import stream_buffer_pkg::*;

	feature_t          wdata_1;
	logic [ADDR_W-1:0] raddr_0;
	logic [ADDR_W-1:0] raddr_1;
	logic              active_0;
	logic              active_1;
	logic              last_0;
	logic              last_1;
	logic              issue_0;
	logic              issue_1;
	logic              finished_0;
	logic              finished_1;
	logic              seen_0;
	logic              seen_1;
	logic              both_done;

	// bank 1 takes pooling or element-wise results.
	assign wdata_1 = i_eltwise_sel ? i_eltwise : i_pool;

	feature_ram #(
		.ADDR_W(ADDR_W)
	) u_bank_0 (
		.clk     (clk),
		.i_wen   (i_wen0),
		.i_waddr (i_waddr0),
		.i_wdata (i_ddr),
		.i_raddr (raddr_0),
		.o_rdata (o_feature_0)
	);

	feature_ram #(
		.ADDR_W(ADDR_W)
	) u_bank_1 (
		.clk     (clk),
		.i_wen   (i_wen1),
		.i_waddr (i_waddr1),
		.i_wdata (wdata_1),
		.i_raddr (raddr_1),
		.o_rdata (o_feature_1)
	);

	scan_addr_gen #(
		.ADDR_W        (ADDR_W),
		.LANES         (LANES),
		.CHANNELS      (CHANNELS),
		.WINDOW_STRIDE (WINDOW_STRIDE),
		.NUM_WINDOWS   (NUM_WINDOWS)
	) u_scan_0 (
		.clk       (clk),
		.i_reset   (i_reset),
		.i_start   (i_start),
		.i_advance (issue_0),
		.o_raddr   (raddr_0),
		.o_active  (active_0),
		.o_last    (last_0)
	);

	scan_addr_gen #(
		.ADDR_W        (ADDR_W),
		.LANES         (LANES),
		.CHANNELS      (CHANNELS),
		.WINDOW_STRIDE (WINDOW_STRIDE),
		.NUM_WINDOWS   (NUM_WINDOWS)
	) u_scan_1 (
		.clk       (clk),
		.i_reset   (i_reset),
		.i_start   (i_start),
		.i_advance (issue_1),
		.o_raddr   (raddr_1),
		.o_active  (active_1),
		.o_last    (last_1)
	);

	credit_sender #(
		.CREDITS(CREDITS)
	) u_sender_0 (
		.clk        (clk),
		.i_reset    (i_reset),
		.i_active   (active_0),
		.i_last     (last_0),
		.i_credit   (i_credit_0),
		.o_issue    (issue_0),
		.o_valid    (o_valid_0),
		.o_finished (finished_0)
	);

	credit_sender #(
		.CREDITS(CREDITS)
	) u_sender_1 (
		.clk        (clk),
		.i_reset    (i_reset),
		.i_active   (active_1),
		.i_last     (last_1),
		.i_credit   (i_credit_1),
		.o_issue    (issue_1),
		.o_valid    (o_valid_1),
		.o_finished (finished_1)
	);

	// fires with the later of the two final words.
	assign both_done = (seen_0 | finished_0) & (seen_1 | finished_1);
	assign o_done    = both_done;

	always_ff @(posedge clk) begin
		if (i_reset) begin
			seen_0 <= 1'b0;
			seen_1 <= 1'b0;
		end else if (both_done) begin
			seen_0 <= 1'b0; // ready for the next pass.
			seen_1 <= 1'b0;
		end else begin
			seen_0 <= seen_0 | finished_0;
			seen_1 <= seen_1 | finished_1;
		end
	end

endmodule

/* bench/stream_buffer_asserts.sv */
`timescale 1ns/1ps

module stream_buffer_asserts #(
	parameter int CREDITS = stream_buffer_pkg::DEF_CREDITS
) (
	input logic clk,
	input logic i_reset,
	input logic i_start,
	input logic i_issue_0,
	input logic i_issue_1,
	input logic i_active_0,
	input logic i_active_1,
	input logic i_credit_0,
	input logic i_credit_1,
	input logic i_valid_0,
	input logic i_valid_1,
	input logic i_done
);

	import stream_buffer_pkg::*;

	int   fail_count = 0;
	int   outstanding_0;
	int   outstanding_1;
	logic started;

	// words issued and not yet paid back by the consumer.
	always_ff @(posedge clk) begin
		if (i_reset) begin
			outstanding_0 <= 0;
			outstanding_1 <= 0;
			started       <= 1'b0;
		end else begin
			outstanding_0 <= outstanding_0 + int'(i_issue_0) - int'(i_credit_0);
			outstanding_1 <= outstanding_1 + int'(i_issue_1) - int'(i_credit_1);
			started       <= started | i_start;
		end
	end

	a_quiet: assert property (@(posedge clk) disable iff (i_reset)
		!started |-> (!i_valid_0 && !i_valid_1 && !i_done))
		else begin
			$error("output active before the first start");
			fail_count++;
		end

	a_credit_0: assert property (@(posedge clk) disable iff (i_reset)
		(outstanding_0 >= 0) && (outstanding_0 <= CREDITS))
		else begin
			$error("stream 0 has more words in flight than credits");
			fail_count++;
		end

	a_credit_1: assert property (@(posedge clk) disable iff (i_reset)
		(outstanding_1 >= 0) && (outstanding_1 <= CREDITS))
		else begin
			$error("stream 1 has more words in flight than credits");
			fail_count++;
		end

	// an active pass with credit left must send.
	a_issue_ready: assert property (@(posedge clk) disable iff (i_reset)
		((i_active_0 && (outstanding_0 < CREDITS)) |-> i_issue_0) and
		((i_active_1 && (outstanding_1 < CREDITS)) |-> i_issue_1))
		else begin
			$error("an active stream held back a word while it had credit");
			fail_count++;
		end

	a_latency: assert property (@(posedge clk) disable iff (i_reset)
		(i_issue_0 |-> ##(READ_LATENCY) i_valid_0) and
		(i_issue_1 |-> ##(READ_LATENCY) i_valid_1))
		else begin
			$error("valid does not follow issue by the read latency");
			fail_count++;
		end

	a_done_pulse: assert property (@(posedge clk) disable iff (i_reset)
		i_done |-> (i_valid_0 || i_valid_1) ##1 !i_done)
		else begin
			$error("done is not a single pulse on a final word");
			fail_count++;
		end

endmodule

bind stream_buffer stream_buffer_asserts #(
	.CREDITS(CREDITS)
) u_asserts (
	.clk        (clk),
	.i_reset    (i_reset),
	.i_start    (i_start),
	.i_issue_0  (issue_0),
	.i_issue_1  (issue_1),
	.i_active_0 (active_0),
	.i_active_1 (active_1),
	.i_credit_0 (i_credit_0),
	.i_credit_1 (i_credit_1),
	.i_valid_0  (o_valid_0),
	.i_valid_1  (o_valid_1),
	.i_done     (o_done)
);

/* bench/stream_buffer_tb.sv */
`timescale 1ns/1ps

module stream_buffer_tb;

	import stream_buffer_pkg::*;

	localparam int ADDR_W        = 8;
	localparam int LANES         = 4;
	localparam int CHANNELS      = 4;
	localparam int WINDOW_STRIDE = 4;
	localparam int NUM_WINDOWS   = 6;
	localparam int CREDITS       = 4;
	localparam int DEPTH         = 2 ** ADDR_W;
	localparam int ELEMENTS      = NUM_WINDOWS * CHANNELS * LANES;
	localparam int CLK_PERIOD    = 8;
	localparam int MAX_GAP       = 7;
	localparam int NUM_PASSES    = 6;
	localparam int WATCHDOG_NS   = 4 * NUM_PASSES * ELEMENTS * (MAX_GAP + 1) * CLK_PERIOD;

	logic              clk;
	logic              i_reset;
	logic              i_start;
	logic              i_wen0;
	logic [ADDR_W-1:0] i_waddr0;
	feature_t          i_ddr;
	logic              i_wen1;
	logic [ADDR_W-1:0] i_waddr1;
	feature_t          i_pool;
	feature_t          i_eltwise;
	logic              i_eltwise_sel;
	logic              i_credit_0;
	logic              i_credit_1;
	feature_t          o_feature_0;
	logic              o_valid_0;
	feature_t          o_feature_1;
	logic              o_valid_1;
	logic              o_done;

	feature_t    shadow_0 [0:DEPTH-1];
	feature_t    shadow_1 [0:DEPTH-1];
	int          count [2];
	int          exp_lane [2];
	int          exp_chan [2];
	int          exp_win [2];
	int          pending [2];
	int          gap [2];
	int          max_gap = 0;
	int          done_count = 0;
	int          errors = 0;
	int          n_pass = 0;
	int          n_fail = 0;
	logic        started = 1'b0;
	logic [31:0] rng = 32'd46;

	stream_buffer #(
		.ADDR_W        (ADDR_W),
		.LANES         (LANES),
		.CHANNELS      (CHANNELS),
		.WINDOW_STRIDE (WINDOW_STRIDE),
		.NUM_WINDOWS   (NUM_WINDOWS),
		.CREDITS       (CREDITS)
	) u_stream_buffer (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	function automatic int total_errors();
		return errors + u_stream_buffer.u_asserts.fail_count;
	endfunction

	// compares one word against the shadow bank at the next scan address.
	task automatic check_word(input int k, input feature_t got);
		int       addr;
		feature_t exp;
		if (count[k] >= ELEMENTS) begin
			$display("stream %0d sent more words than one pass holds at %0t", k, $time);
			errors++;
			return;
		end
		addr = exp_win[k] * WINDOW_STRIDE + exp_chan[k] + exp_lane[k];
		exp  = (k == 0) ? shadow_0[addr] : shadow_1[addr];
		assert (got === exp) else begin
			$display("FAILED %0t o_feature_%0d expected %h got %h", $time, k, exp, got);
			errors++;
		end
		count[k]++;
		if (exp_lane[k] == LANES - 1) begin
			exp_lane[k] = 0;
			if (exp_chan[k] == CHANNELS - 1) begin
				exp_chan[k] = 0;
				exp_win[k]++;
			end else begin
				exp_chan[k]++;
			end
		end else begin
			exp_lane[k]++;
		end
	endtask

	always @(posedge clk) begin
		if (!i_reset) begin
			if (!started) begin
				assert (!o_valid_0 && !o_valid_1 && !o_done) else begin
					$display("outputs went active before any start at %0t", $time);
					errors++;
				end
			end
			if (o_valid_0) check_word(0, o_feature_0);
			if (o_valid_1) check_word(1, o_feature_1);
			if (o_done) begin
				done_count++;
				for (int k = 0; k < 2; k++) begin
					assert (count[k] == ELEMENTS) else begin
						$display("FAILED %0t o_valid_%0d count expected %0d got %0d",
							$time, k, ELEMENTS, count[k]);
						errors++;
					end
				end
			end
		end
	end

	// consumer side, one credit per received word after a random gap.
	always @(posedge clk) begin : credit_return
		logic [1:0] give;
		give = 2'b00;
		for (int k = 0; k < 2; k++) begin
			if (i_reset) begin
				pending[k] = 0;
				gap[k]     = 0;
			end else begin
				if ((k == 0) ? o_valid_0 : o_valid_1) pending[k]++;
				if (gap[k] > 0) begin
					gap[k]--;
				end else if (pending[k] > 0) begin
					give[k] = 1'b1;
					pending[k]--;
					rng    = xorshift(rng);
					gap[k] = int'(rng % 32'(max_gap + 1));
				end
			end
		end
		i_credit_0 <= give[0];
		i_credit_1 <= give[1];
	end

	task automatic load_bank_0();
		feature_t w;
		for (int a = 0; a < DEPTH; a++) begin
			rng = xorshift(rng);
			w   = rng[15:0];
			@(posedge clk);
			i_wen0      <= 1'b1;
			i_waddr0    <= ADDR_W'(a);
			i_ddr       <= w;
			shadow_0[a] = w;
		end
		@(posedge clk);
		i_wen0 <= 1'b0;
	endtask

	task automatic load_bank_1(input bit mixed);
		logic [31:0] r;
		logic        sel;
		for (int a = 0; a < DEPTH; a++) begin
			rng = xorshift(rng);
			r   = rng;
			rng = xorshift(rng);
			sel = mixed & rng[7];
			@(posedge clk);
			i_wen1        <= 1'b1;
			i_waddr1      <= ADDR_W'(a);
			i_pool        <= r[15:0];
			i_eltwise     <= r[31:16];
			i_eltwise_sel <= sel;
			shadow_1[a]   = sel ? r[31:16] : r[15:0];
		end
		@(posedge clk);
		i_wen1        <= 1'b0;
		i_eltwise_sel <= 1'b0;
	endtask

	// one pass, optionally with a second start while it runs.
	task automatic run_pass(input int gap_max, input int restart_delay);
		max_gap    = gap_max;
		done_count = 0;
		for (int k = 0; k < 2; k++) begin
			count[k]    = 0;
			exp_lane[k] = 0;
			exp_chan[k] = 0;
			exp_win[k]  = 0;
		end
		started = 1'b1;
		@(posedge clk);
		i_start <= 1'b1;
		@(posedge clk);
		i_start <= 1'b0;
		if (restart_delay > 0) begin
			repeat (restart_delay) @(posedge clk);
			i_start <= 1'b1;
			@(posedge clk);
			i_start <= 1'b0;
		end
		while (done_count == 0) @(posedge clk);
		repeat (4 * READ_LATENCY) @(posedge clk); // room for a stray word or pulse.
		assert (done_count == 1) else begin
			$display("FAILED %0t o_done pulses expected 1 got %0d", $time, done_count);
			errors++;
		end
		while (pending[0] != 0 || pending[1] != 0) @(posedge clk);
	endtask

	task automatic finish_test(input string name, input int mark);
		if (total_errors() == mark) begin
			$display("test %s passed", name);
			n_pass++;
		end else begin
			$display("test %s failed with %0d errors", name, total_errors() - mark);
			n_fail++;
		end
	endtask

	initial begin : stimulus
		int mark;
		i_reset       <= 1'b1;
		i_start       <= 1'b0;
		i_wen0        <= 1'b0;
		i_waddr0      <= '0;
		i_ddr         <= '0;
		i_wen1        <= 1'b0;
		i_waddr1      <= '0;
		i_pool        <= '0;
		i_eltwise     <= '0;
		i_eltwise_sel <= 1'b0;
		i_credit_0    <= 1'b0;
		i_credit_1    <= 1'b0;
		repeat (10) @(posedge clk);
		i_reset <= 1'b0;

		mark = total_errors();
		repeat (20) @(posedge clk);
		finish_test("reset_idle", mark);

		mark = total_errors();
		load_bank_0();
		load_bank_1(1'b0);
		run_pass(0, 0);
		finish_test("bank0_ddr_stream", mark);

		mark = total_errors();
		load_bank_1(1'b1);
		run_pass(0, 0);
		finish_test("bank1_pool_eltwise", mark);

		mark = total_errors();
		run_pass(MAX_GAP, 0);
		finish_test("random_credit_return", mark);

		mark = total_errors();
		run_pass(3, 0);
		run_pass(1, 0);
		finish_test("done_once_per_pass", mark);

		mark = total_errors();
		run_pass(2, 20);
		finish_test("start_during_pass", mark);

		$display("summary: %0d tests passed, %0d tests failed, %0d errors",
			n_pass, n_fail, total_errors());
		if (n_fail == 0 && total_errors() == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired, the passes did not finish in the expected time");
		$display("Test FAILED");
		$finish;
	end

endmodule

/* verilog.f */
logic/stream_buffer_pkg.sv
logic/feature_ram.sv
logic/scan_addr_gen.sv
logic/credit_sender.sv
logic/stream_buffer.sv
bench/stream_buffer_asserts.sv
bench/stream_buffer_tb.sv
